// File: sim.f
+incdir+include
source/imuldiv_pkg.sv
source/imuldiv_req_queue.sv
source/imuldiv_div_ctrl.sv
source/imuldiv_div_dpath.sv
source/imuldiv_div_unit.sv
test/imuldiv_checker.sv
test/imuldiv_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the divider testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module imuldiv_tb -o imuldiv_sim

sim_out=$(./obj_dir/imuldiv_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Finished with no errors"; then
  exit 0
else
  exit 1
fi

// File: test/imuldiv_tb.sv
// divider testbench top
// seeded random and corner divides, back-pressure and queue fill phases

`timescale 1ns/10ps

`include "imuldiv_defines.svh"

module imuldiv_tb import imuldiv_pkg::*; ();

  localparam int SEND_TIMEOUT  = 300;
  localparam int DRAIN_TIMEOUT = 6000;
  localparam int FILL_TIMEOUT  = 400;

  logic                         clk;
  logic                         reset;
  div_fn_e                      req_fn;
  logic [`IMULDIV_DATA_W-1:0]   req_a;
  logic [`IMULDIV_DATA_W-1:0]   req_b;
  logic                         req_val;
  logic                         req_rdy;
  logic [`IMULDIV_RESULT_W-1:0] resp_result;
  logic                         resp_val;
  logic                         resp_rdy;

  int seed;
  // 0 holds resp_rdy low, 1 holds it high, 2 toggles it randomly
  int rdy_mode;
  int tb_errs;
  int chk_errs;
  int chk_reqs;
  int chk_resps;
  bit timed_out;

  imuldiv_div_unit dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  imuldiv_checker checker_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .err_count   (chk_errs),
    .req_count   (chk_reqs),
    .resp_count  (chk_resps)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // stimulus helpers
  // --------------------

  // step to 1 ns past the next rising edge and update resp_rdy
  task automatic next_cycle();
    int rnd;
    @(posedge clk);
    #1;
    rnd = $random(seed);
    if (rdy_mode == 2) begin
      resp_rdy = rnd[0];
    end else begin
      resp_rdy = (rdy_mode == 1);
    end
  endtask

  // top bit forced on three times in four when biased
  function automatic logic [`IMULDIV_DATA_W-1:0] rand_operand(input bit neg_bias);
    logic [`IMULDIV_DATA_W-1:0] v;
    int                         sel;
    v   = $random(seed);
    sel = $random(seed);
    if (neg_bias && (sel[1:0] != 2'b00)) begin
      v[`IMULDIV_DATA_W-1] = 1'b1;
    end
    return v;
  endfunction

  // divisors of mixed size, so quotients are not always tiny
  function automatic logic [`IMULDIV_DATA_W-1:0] rand_divisor(input bit neg_bias);
    logic [`IMULDIV_DATA_W-1:0] v;
    int                         sel;
    v   = $random(seed);
    sel = $random(seed);
    v   = v >> sel[4:0];
    if (neg_bias && (sel[6:5] != 2'b00)) begin
      v = ~v + 1'b1;
    end
    return v;
  endfunction

  // hold one request until the queue takes it
  task automatic send_req(input div_fn_e fn, input logic [`IMULDIV_DATA_W-1:0] a,
                          input logic [`IMULDIV_DATA_W-1:0] b);
    int   waited;
    logic taken;
    waited  = 0;
    taken   = 1'b0;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    while (!taken && !timed_out) begin
      // req_rdy only moves at clock edges, so it is settled here
      taken = req_rdy;
      next_cycle();
      waited++;
      if (!taken && (waited >= SEND_TIMEOUT)) begin
        $display("timeout: request was not accepted within %0d cycles", waited);
        timed_out = 1'b1;
      end
    end
    req_val = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((chk_resps != chk_reqs) && !timed_out) begin
      next_cycle();
      waited++;
      if (waited >= DRAIN_TIMEOUT) begin
        $display("timeout: %0d responses still missing after %0d cycles",
                 chk_reqs - chk_resps, waited);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic report_phase(input string name);
    $display("phase %s: %s, %0d requests, %0d responses so far", name,
             (chk_errs + tb_errs == 0 && !timed_out) ? "ok" : "errors seen", chk_reqs, chk_resps);
  endtask

  // --------------------
  // test phases
  // --------------------

  task automatic run_corners();
    div_fn_e fn;
    for (int m = 0; m < 2; m++) begin
      fn = (m == 0) ? DIV_FN_UNSIGNED : DIV_FN_SIGNED;
      send_req(fn, 32'h1234_5678, 32'h0000_0000);
      send_req(fn, 32'hffff_fff9, 32'h0000_0000);
      send_req(fn, 32'h8000_0000, 32'hffff_ffff);
      send_req(fn, 32'h0000_0005, 32'h0000_0064);
      send_req(fn, 32'hffff_fffb, 32'h0000_0064);
      send_req(fn, 32'hdead_beef, 32'h0000_0001);
      send_req(fn, 32'h8000_0000, 32'h0000_0001);
    end
  endtask

  // stall the output, offer requests until req_rdy has stayed low for 40 cycles
  task automatic fill_queue();
    int   accepted;
    int   low_run;
    int   cycles;
    logic taken;
    accepted = 0;
    low_run  = 0;
    cycles   = 0;
    rdy_mode = 0;
    resp_rdy = 1'b0;
    req_fn   = DIV_FN_SIGNED;
    req_a    = rand_operand(1'b1);
    req_b    = rand_divisor(1'b1);
    req_val  = 1'b1;
    while ((low_run < 40) && !timed_out) begin
      taken = req_rdy;
      next_cycle();
      cycles++;
      if (taken) begin
        accepted++;
        low_run = 0;
        req_a   = rand_operand(1'b1);
        req_b   = rand_divisor(1'b1);
      end else begin
        low_run++;
      end
      if (cycles >= FILL_TIMEOUT) begin
        $display("timeout: req_rdy never stayed low for 40 cycles");
        timed_out = 1'b1;
      end
    end
    req_val = 1'b0;
    if (accepted != `IMULDIV_QUEUE_DEPTH + 1) begin
      $display("FAIL t=%0t accepted_count expected %0d got %0d", $time,
               `IMULDIV_QUEUE_DEPTH + 1, accepted);
      tb_errs++;
    end
    rdy_mode = 1;
    wait_drain();
  endtask

  task automatic run_phases();
    // 1: unsigned, output always ready
    rdy_mode = 1;
    for (int i = 0; i < 24; i++) begin
      send_req(DIV_FN_UNSIGNED, rand_operand(1'b0), rand_divisor(1'b0));
    end
    wait_drain();
    report_phase("unsigned random");
    if (timed_out) return;

    // 2: signed, mostly negative operands
    for (int i = 0; i < 24; i++) begin
      send_req(DIV_FN_SIGNED, rand_operand(1'b1), rand_divisor(1'b1));
    end
    wait_drain();
    report_phase("signed random");
    if (timed_out) return;

    // 3: zero divisor, overflow, small dividend, divide by one
    run_corners();
    wait_drain();
    report_phase("corner operands");
    if (timed_out) return;

    // 4: random output stalls, both modes mixed
    rdy_mode = 2;
    for (int i = 0; i < 20; i++) begin
      send_req((i % 2 == 0) ? DIV_FN_SIGNED : DIV_FN_UNSIGNED,
               rand_operand(1'b1), rand_divisor(1'b1));
    end
    wait_drain();
    rdy_mode = 1;
    report_phase("random back-pressure");
    if (timed_out) return;

    // 5: queue fill then drain
    fill_queue();
    report_phase("queue fill");
  endtask

  initial begin
    seed      = 49891;
    rdy_mode  = 0;
    tb_errs   = 0;
    timed_out = 1'b0;
    reset     = 1'b1;
    req_fn    = DIV_FN_UNSIGNED;
    req_a     = '0;
    req_b     = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    run_phases();

    $display("summary: %0d requests, %0d responses, %0d errors, timeout %0d",
             chk_reqs, chk_resps, chk_errs + tb_errs, timed_out);
    if ((chk_errs + tb_errs == 0) && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: test/imuldiv_checker.sv
// divider response checker
// models each accepted request and compares results in request order

`timescale 1ns/10ps

`include "imuldiv_defines.svh"

module imuldiv_checker import imuldiv_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  div_fn_e                      req_fn,
  input  logic [`IMULDIV_DATA_W-1:0]   req_a,
  input  logic [`IMULDIV_DATA_W-1:0]   req_b,
  input  logic                         req_val,
  input  logic                         req_rdy,
  input  logic [`IMULDIV_RESULT_W-1:0] resp_result,
  input  logic                         resp_val,
  input  logic                         resp_rdy,
  output int                           err_count,
  output int                           req_count,
  output int                           resp_count
);

  // expected {remainder, quotient} per accepted request, oldest first
  logic [`IMULDIV_RESULT_W-1:0] exp_q [$];
  logic [`IMULDIV_RESULT_W-1:0] expected;
  logic [`IMULDIV_RESULT_W-1:0] held_val;
  logic                         held;

  // magnitudes divided, then signs applied, all wrapping at 32 bits
  function automatic logic [`IMULDIV_RESULT_W-1:0] divide_model(
    input div_fn_e fn, input logic [`IMULDIV_DATA_W-1:0] a, input logic [`IMULDIV_DATA_W-1:0] b);
    logic                       a_neg;
    logic                       b_neg;
    logic [`IMULDIV_DATA_W-1:0] a_abs;
    logic [`IMULDIV_DATA_W-1:0] b_abs;
    logic [`IMULDIV_DATA_W-1:0] q;
    logic [`IMULDIV_DATA_W-1:0] r;
    a_neg = (fn == DIV_FN_SIGNED) && a[`IMULDIV_DATA_W-1];
    b_neg = (fn == DIV_FN_SIGNED) && b[`IMULDIV_DATA_W-1];
    a_abs = a_neg ? (~a + 1'b1) : a;
    b_abs = b_neg ? (~b + 1'b1) : b;
    // zero divisor gives all-ones quotient and the dividend magnitude as remainder
    if (b_abs == '0) begin
      q = '1;
      r = a_abs;
    end else begin
      q = a_abs / b_abs;
      r = a_abs % b_abs;
    end
    if (a_neg != b_neg) begin
      q = ~q + 1'b1;
    end
    if (a_neg) begin
      r = ~r + 1'b1;
    end
    return {r, q};
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      exp_q.delete();
      err_count  = 0;
      req_count  = 0;
      resp_count = 0;
      held       = 1'b0;
      held_val   = '0;
    end else begin
      // --------------------
      // result must hold while stalled
      if (held && resp_val && (resp_result !== held_val)) begin
        $display("FAIL t=%0t resp_result expected %h got %h (changed under back-pressure)",
                 $time, held_val, resp_result);
        err_count++;
      end
      held     = resp_val && !resp_rdy;
      held_val = resp_result;

      // --------------------
      // request side
      if (req_val && req_rdy) begin
        exp_q.push_back(divide_model(req_fn, req_a, req_b));
        req_count++;
      end

      // response side, in order
      if (resp_val && resp_rdy) begin
        resp_count++;
        if (exp_q.size() == 0) begin
          $display("error at t=%0t: a response arrived with no request outstanding", $time);
          err_count++;
        end else begin
          expected = exp_q.pop_front();
          if (resp_result !== expected) begin
            $display("FAIL t=%0t resp_result expected %h got %h", $time, expected, resp_result);
            err_count++;
          end
        end
      end
    end
  end

endmodule

// File: source/imuldiv_div_unit.sv
// iterative divide unit
// request queue feeding one restoring divider, val/rdy on both sides

`timescale 1ns/10ps

`include "imuldiv_defines.svh"

module imuldiv_div_unit import imuldiv_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  div_fn_e                      req_fn,
  input  logic [`IMULDIV_DATA_W-1:0]   req_a,
  input  logic [`IMULDIV_DATA_W-1:0]   req_b,
  input  logic                         req_val,
  output logic                         req_rdy,
  output logic [`IMULDIV_RESULT_W-1:0] resp_result,
  output logic                         resp_val,
  input  logic                         resp_rdy
);

  // queue head toward the divider
  div_fn_e                    q_fn;
  logic [`IMULDIV_DATA_W-1:0] q_a;
  logic [`IMULDIV_DATA_W-1:0] q_b;
  logic                       q_val;
  logic                       q_rdy;

  // control to datapath
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic cntr_mux_sel;
  logic sign_en;
  logic counter_is_zero;

  imuldiv_req_queue req_queue_i (
    .clk     (clk),
    .reset   (reset),
    .in_fn   (req_fn),
    .in_a    (req_a),
    .in_b    (req_b),
    .in_val  (req_val),
    .in_rdy  (req_rdy),
    .out_fn  (q_fn),
    .out_a   (q_a),
    .out_b   (q_b),
    .out_val (q_val),
    .out_rdy (q_rdy)
  );

  imuldiv_div_ctrl ctrl_i (
    .clk             (clk),
    .reset           (reset),
    .req_val         (q_val),
    .req_rdy         (q_rdy),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .counter_is_zero (counter_is_zero),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en)
  );

  imuldiv_div_dpath dpath_i (
    .clk             (clk),
    .reset           (reset),
    .fn              (q_fn),
    .a               (q_a),
    .b               (q_b),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .counter_is_zero (counter_is_zero),
    .result          (resp_result)
  );

endmodule

// File: source/imuldiv_div_dpath.sv
// divider datapath
// restoring shift-subtract on operand magnitudes, then sign correction

`timescale 1ns/10ps

`include "imuldiv_defines.svh"

module imuldiv_div_dpath import imuldiv_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  div_fn_e                      fn,
  input  logic [`IMULDIV_DATA_W-1:0]   a,
  input  logic [`IMULDIV_DATA_W-1:0]   b,
  input  logic                         a_en,
  input  logic                         b_en,
  input  logic                         a_mux_sel,
  input  logic                         cntr_mux_sel,
  input  logic                         sign_en,
  output logic                         counter_is_zero,
  output logic [`IMULDIV_RESULT_W-1:0] result
);

  localparam int DW    = `IMULDIV_DATA_W;
  localparam int CNT_W = `IMULDIV_CNT_W;
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`IMULDIV_ITERS - 1);

  // {borrow, remainder, quotient} and {0, divisor, zeros}
  logic [2*DW:0]    a_reg;
  logic [2*DW:0]    b_reg;
  logic [CNT_W-1:0] counter_reg;

  // stored sign info
  logic signed_reg;
  logic quot_neg_reg;
  logic rem_neg_reg;

  // ------------------
  // operand normalization
  // ------------------
  logic          is_signed;
  logic [DW-1:0] a_mag;
  logic [DW-1:0] b_mag;

  assign is_signed = (fn == DIV_FN_SIGNED);
  assign a_mag = (is_signed && a[DW-1]) ? (~a + 1'b1) : a;
  assign b_mag = (is_signed && b[DW-1]) ? (~b + 1'b1) : b;

  // ------------------
  // shift-subtract step
  // ------------------
  logic [2*DW:0] a_shift;
  logic [2*DW:0] diff;
  logic [2*DW:0] step_out;

  assign a_shift = a_reg << 1;
  assign diff    = a_shift - b_reg;
  // borrow set means divisor did not fit, restore and shift in a zero
  assign step_out = diff[2*DW] ? {a_shift[2*DW:1], 1'b0} : {diff[2*DW:1], 1'b1};

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_sel ? step_out : {{(DW+1){1'b0}}, a_mag};
    end
    if (b_en) begin
      b_reg <= {1'b0, b_mag, {DW{1'b0}}};
    end
  end

  // iteration counter, reloads whenever not stepping
  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg  <= '0;
      signed_reg   <= 1'b0;
      quot_neg_reg <= 1'b0;
      rem_neg_reg  <= 1'b0;
    end else begin
      counter_reg <= cntr_mux_sel ? (counter_reg - 1'b1) : CNT_LOAD;
      if (sign_en) begin
        signed_reg   <= is_signed;
        quot_neg_reg <= a[DW-1] ^ b[DW-1];
        rem_neg_reg  <= a[DW-1];
      end
    end
  end

  assign counter_is_zero = (counter_reg == '0);

  // ------------------
  // sign correction
  // ------------------
  logic [DW-1:0] quot;
  logic [DW-1:0] rem;

  assign quot = a_reg[DW-1:0];
  assign rem  = a_reg[2*DW-1:DW];

  // wraps at DW bits, so min / -1 comes back as min
  assign result[DW-1:0]    = (signed_reg && quot_neg_reg) ? (~quot + 1'b1) : quot;
  assign result[2*DW-1:DW] = (signed_reg && rem_neg_reg) ? (~rem + 1'b1) : rem;

  // response held steady across back-pressure
  a_result_hold: assert property (@(posedge clk) disable iff (reset)
    (!a_en && !b_en && !sign_en) |=> $stable(result));

endmodule

// File: source/imuldiv_div_ctrl.sv
// divider control
// idle/calc/done FSM driving datapath enables and both val/rdy handshakes

`timescale 1ns/10ps

`include "imuldiv_defines.svh"

module imuldiv_div_ctrl import imuldiv_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  input  logic counter_is_zero,
  output logic a_en,
  output logic b_en,
  output logic a_mux_sel,
  output logic cntr_mux_sel,
  output logic sign_en
);

  div_state_e state;

  logic req_go;
  logic resp_go;

  // request popped only from idle
  assign req_go  = (state == DIV_IDLE) && req_val;
  // response taken only from done
  assign resp_go = (state == DIV_DONE) && resp_rdy;

  // ------------------
  // state register
  // ------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= DIV_IDLE;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (req_go) begin
            state <= DIV_CALC;
          end
        end
        // last iteration runs while the counter reads zero
        DIV_CALC: begin
          if (counter_is_zero) begin
            state <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          if (resp_go) begin
            state <= DIV_IDLE;
          end
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  // ------------------
  // output decode
  // ------------------
  always_comb begin
    req_rdy      = 1'b0;
    resp_val     = 1'b0;
    a_en         = 1'b0;
    b_en         = 1'b0;
    a_mux_sel    = 1'b0;
    cntr_mux_sel = 1'b0;
    sign_en      = 1'b0;
    case (state)
      DIV_IDLE: begin
        // load operands, sign flags and counter on the pop
        req_rdy = 1'b1;
        a_en    = req_go;
        b_en    = req_go;
        sign_en = req_go;
      end
      DIV_CALC: begin
        // one shift-subtract step per cycle, counter counts down
        a_en         = 1'b1;
        a_mux_sel    = 1'b1;
        cntr_mux_sel = 1'b1;
      end
      DIV_DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {DIV_IDLE, DIV_CALC, DIV_DONE});

  // never accept a new divide while a result is still offered
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val));

endmodule

// File: source/imuldiv_req_queue.sv
// divide request queue
// circular buffer of {fn, a, b} entries with val/rdy on both sides, no bypass

`timescale 1ns/10ps

`include "imuldiv_defines.svh"

module imuldiv_req_queue import imuldiv_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  div_fn_e                    in_fn,
  input  logic [`IMULDIV_DATA_W-1:0] in_a,
  input  logic [`IMULDIV_DATA_W-1:0] in_b,
  input  logic                       in_val,
  output logic                       in_rdy,
  output div_fn_e                    out_fn,
  output logic [`IMULDIV_DATA_W-1:0] out_a,
  output logic [`IMULDIV_DATA_W-1:0] out_b,
  output logic                       out_val,
  input  logic                       out_rdy
);

  localparam int DEPTH = `IMULDIV_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // entry storage
  div_fn_e                    fn_mem [DEPTH];
  logic [`IMULDIV_DATA_W-1:0] a_mem  [DEPTH];
  logic [`IMULDIV_DATA_W-1:0] b_mem  [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic full;
  logic push;
  logic pop;

  assign full    = (count == CNT_W'(DEPTH));
  assign in_rdy  = !full;
  assign out_val = (count != '0);

  assign push = in_val && in_rdy;
  assign pop  = out_val && out_rdy;

  // head entry always presented
  assign out_fn = fn_mem[rd_ptr];
  assign out_a  = a_mem[rd_ptr];
  assign out_b  = b_mem[rd_ptr];

  // ------------------
  // pointers and occupancy
  // ------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own for power-of-two depth
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // payload write, no reset needed
  always_ff @(posedge clk) begin
    if (push) begin
      fn_mem[wr_ptr] <= in_fn;
      a_mem[wr_ptr]  <= in_a;
      b_mem[wr_ptr]  <= in_b;
    end
  end

  // occupancy never leaves 0..DEPTH, so no write landed on a full queue
  // and no pop was taken from an empty one
  a_count_in_range: assert property (@(posedge clk) disable iff (reset)
    count <= CNT_W'(DEPTH));

  // write pointer leads the read pointer by exactly the occupancy
  a_count_tracks_ptrs: assert property (@(posedge clk) disable iff (reset)
    (wr_ptr - rd_ptr) == count[PTR_W-1:0]);

endmodule

// File: source/imuldiv_pkg.sv
// divider types
// function code carried with each request, and the divider FSM states

package imuldiv_pkg;

  // ------------------
  // request function bit
  // ------------------
  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_e;

  // ------------------
  // divider FSM
  // ------------------
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_CALC = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

endpackage

// File: include/imuldiv_defines.svh
// divider widths, iteration count and request queue depth
// shared by the queue, control and datapath

`ifndef IMULDIV_DEFINES_SVH
`define IMULDIV_DEFINES_SVH

// operand width and packed {remainder, quotient} width
`define IMULDIV_DATA_W 32
`define IMULDIV_RESULT_W 64

// one shift-subtract step per quotient bit
`define IMULDIV_ITERS 32
`define IMULDIV_CNT_W 5

// request buffer entries, power of two
`define IMULDIV_QUEUE_DEPTH 4

`endif
